//--- flist.f
rtl/dsp_ctrl_pkg.sv
rtl/wb_regfile_2clock.sv
rtl/phase_accum.sv
rtl/atr_gpio.sv
rtl/dsp_ctrl_top.sv
sim/dsp_ctrl_assert.sv
sim/tb_dsp_ctrl_top.sv

//--- rtl/atr_gpio.sv
`timescale 1ns/1ps

module atr_gpio
(
   input  logic                alt_clk,
   input  logic                alt_rst,
   input  logic                run_i,
   input  dsp_ctrl_pkg::gpio_t  idle_val_i,
   input  dsp_ctrl_pkg::gpio_t  active_val_i,
   output dsp_ctrl_pkg::gpio_t  gpio_o
);

   import dsp_ctrl_pkg::*;

   gpio_t sel_val;
   gpio_t gpio_q;

   // pick the word for the current transmit/receive state
   always_comb
   begin
      if (run_i)
      begin
         sel_val = active_val_i;
      end
      else
      begin
         sel_val = idle_val_i;
      end
   end

   // pins stay low after reset until software sets the idle word
   always_ff @(posedge alt_clk)
   begin
      if (alt_rst)
      begin
         gpio_q <= '0;
      end
      else
      begin
         gpio_q <= sel_val;
      end
   end

   assign gpio_o = gpio_q;

endmodule

//--- rtl/dsp_ctrl_pkg.sv
package dsp_ctrl_pkg;

   // settings word and byte lane geometry
   localparam int WORD_W    = 32;
   localparam int BYTE_W    = 8;
   localparam int NUM_BYTES = WORD_W / BYTE_W;

   // register file geometry
   localparam int NUM_REGS  = 8;
   localparam int IDX_W     = $clog2(NUM_REGS);
   localparam int ADDR_LSB  = 2;
   localparam int ADDR_W    = 16;

   // GPIO driver width, taken from the low half of a settings word
   localparam int GPIO_W    = 16;

   // accumulator enable position inside register 1
   localparam int ENA_BIT   = 0;

   // settings words and phase values share one width
   typedef logic [WORD_W-1:0]    word_t;

   // register index, taken from byte address bits 4 to 2
   typedef logic [IDX_W-1:0]     reg_idx_t;

   typedef logic [ADDR_W-1:0]    wb_addr_t;

   // bit n enables byte n of the data word
   typedef logic [NUM_BYTES-1:0] byte_sel_t;

   typedef logic [GPIO_W-1:0]    gpio_t;

endpackage

//--- rtl/dsp_ctrl_top.sv
`timescale 1ns/1ps

module dsp_ctrl_top
(
   input  logic                   wb_clk_i,
   input  logic                   wb_rst_i,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   input  dsp_ctrl_pkg::wb_addr_t  wb_adr_i,
   input  dsp_ctrl_pkg::byte_sel_t wb_sel_i,
   input  dsp_ctrl_pkg::word_t     wb_dat_i,
   output logic                   wb_ack_o,

   input  logic                   alt_clk,
   input  logic                   alt_rst,
   input  logic                   run_i,

   output dsp_ctrl_pkg::word_t     phase_o,
   output dsp_ctrl_pkg::gpio_t     gpio_o,
   output dsp_ctrl_pkg::word_t     user_reg4_o,
   output dsp_ctrl_pkg::word_t     user_reg5_o,
   output dsp_ctrl_pkg::word_t     user_reg6_o,
   output dsp_ctrl_pkg::word_t     user_reg7_o
);

   import dsp_ctrl_pkg::*;

   word_t phase_inc;
   word_t phase_ctrl;
   word_t atr_idle;
   word_t atr_active;

   wb_regfile_2clock i_wb_regfile_2clock (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_sel_i (wb_sel_i),
      .wb_dat_i (wb_dat_i),
      .wb_ack_o (wb_ack_o),
      .alt_clk  (alt_clk),
      .alt_rst  (alt_rst),
      .reg00_o  (phase_inc),
      .reg01_o  (phase_ctrl),
      .reg02_o  (atr_idle),
      .reg03_o  (atr_active),
      .reg04_o  (user_reg4_o),
      .reg05_o  (user_reg5_o),
      .reg06_o  (user_reg6_o),
      .reg07_o  (user_reg7_o)
   );

   phase_accum i_phase_accum (
      .alt_clk     (alt_clk),
      .alt_rst     (alt_rst),
      .phase_inc_i (phase_inc),
      .enable_i    (phase_ctrl[ENA_BIT]),
      .phase_o     (phase_o)
   );

   // only the low half of the ATR words reaches the pins
   atr_gpio i_atr_gpio (
      .alt_clk      (alt_clk),
      .alt_rst      (alt_rst),
      .run_i        (run_i),
      .idle_val_i   (atr_idle[GPIO_W-1:0]),
      .active_val_i (atr_active[GPIO_W-1:0]),
      .gpio_o       (gpio_o)
   );

endmodule

//--- rtl/phase_accum.sv
`timescale 1ns/1ps

module phase_accum
(
   input  logic                alt_clk,
   input  logic                alt_rst,
   input  dsp_ctrl_pkg::word_t  phase_inc_i,
   input  logic                enable_i,
   output dsp_ctrl_pkg::word_t  phase_o
);

   import dsp_ctrl_pkg::*;

   word_t inc_q;
   logic  ena_q;
   word_t phase_q;

   // settings come from the register file, retime them before the adder
   always_ff @(posedge alt_clk)
   begin
      inc_q <= phase_inc_i;
   end

   always_ff @(posedge alt_clk)
   begin
      if (alt_rst)
      begin
         ena_q <= 1'b0;
      end
      else
      begin
         ena_q <= enable_i;
      end
   end

   // the sum wraps modulo 2^32 by the width of word_t
   always_ff @(posedge alt_clk)
   begin
      if (alt_rst)
      begin
         phase_q <= '0;
      end
      else if (ena_q)
      begin
         phase_q <= phase_q + inc_q;
      end
   end

   assign phase_o = phase_q;

endmodule

//--- rtl/wb_regfile_2clock.sv
`timescale 1ns/1ps

module wb_regfile_2clock
(
   input  logic                   wb_clk_i,
   input  logic                   wb_rst_i,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   input  dsp_ctrl_pkg::wb_addr_t  wb_adr_i,
   input  dsp_ctrl_pkg::byte_sel_t wb_sel_i,
   input  dsp_ctrl_pkg::word_t     wb_dat_i,
   output logic                   wb_ack_o,

   input  logic                   alt_clk,
   input  logic                   alt_rst,

   output dsp_ctrl_pkg::word_t     reg00_o,
   output dsp_ctrl_pkg::word_t     reg01_o,
   output dsp_ctrl_pkg::word_t     reg02_o,
   output dsp_ctrl_pkg::word_t     reg03_o,
   output dsp_ctrl_pkg::word_t     reg04_o,
   output dsp_ctrl_pkg::word_t     reg05_o,
   output dsp_ctrl_pkg::word_t     reg06_o,
   output dsp_ctrl_pkg::word_t     reg07_o
);

   import dsp_ctrl_pkg::*;

   // write request held in the bus domain until the next write
   reg_idx_t  idx_q;
   byte_sel_t sel_q;
   word_t     dat_q;

   // registered strobe and write pulse, both one wb_clk_i cycle long
   logic      ack_q;
   logic      wr_q;

   // two-flop synchronizer for the write pulse
   logic      wr_sync1_q;
   logic      wr_sync2_q;

   word_t     settings_q [NUM_REGS];

   // capture the write on the strobe edge, only the index bits matter
   always_ff @(posedge wb_clk_i)
   begin
      if (wb_rst_i)
      begin
         idx_q <= '0;
         sel_q <= '0;
         dat_q <= '0;
      end
      else if (wb_stb_i && wb_we_i)
      begin
         idx_q <= wb_adr_i[ADDR_LSB +: IDX_W];
         sel_q <= wb_sel_i;
         dat_q <= wb_dat_i;
      end
   end

   // reads and writes are acknowledged alike, one cycle after the strobe
   always_ff @(posedge wb_clk_i)
   begin
      if (wb_rst_i)
      begin
         ack_q <= 1'b0;
         wr_q  <= 1'b0;
      end
      else
      begin
         ack_q <= wb_stb_i;
         wr_q  <= wb_stb_i & wb_we_i;
      end
   end

   assign wb_ack_o = ack_q;

   // alt_clk is faster than wb_clk_i, so the pulse is always seen
   always_ff @(posedge alt_clk)
   begin
      if (alt_rst)
      begin
         wr_sync1_q <= 1'b0;
         wr_sync2_q <= 1'b0;
      end
      else
      begin
         wr_sync1_q <= wr_q;
         wr_sync2_q <= wr_sync1_q;
      end
   end

   // the update may repeat for a few alt_clk cycles, which is harmless
   // since the captured request is stable and the merge is idempotent
   always_ff @(posedge alt_clk)
   begin
      if (alt_rst)
      begin
         for (int r = 0; r < NUM_REGS; r++)
         begin
            settings_q[r] <= '0;
         end
      end
      else if (wr_sync2_q)
      begin
         for (int b = 0; b < NUM_BYTES; b++)
         begin
            if (sel_q[b])
            begin
               settings_q[idx_q][BYTE_W*b +: BYTE_W] <= dat_q[BYTE_W*b +: BYTE_W];
            end
         end
      end
   end

   assign reg00_o = settings_q[0];
   assign reg01_o = settings_q[1];
   assign reg02_o = settings_q[2];
   assign reg03_o = settings_q[3];
   assign reg04_o = settings_q[4];
   assign reg05_o = settings_q[5];
   assign reg06_o = settings_q[6];
   assign reg07_o = settings_q[7];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_dsp_ctrl_top \
   && ./obj_dir/Vtb_dsp_ctrl_top | tee /dev/stderr | grep -qx "PASS: all tests" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- sim/dsp_ctrl_assert.sv
`timescale 1ns/1ps

module dsp_ctrl_assert
(
   input logic                wb_clk_i,
   input logic                wb_rst_i,
   input logic                wb_stb_i,
   input logic                wb_ack_o,
   input logic                alt_clk,
   input logic                alt_rst,
   input logic                ena_i,
   input dsp_ctrl_pkg::gpio_t gpio_o,
   input dsp_ctrl_pkg::word_t phase_o
);

   // every single-cycle strobe gets exactly one acknowledge in the next cycle
   ack_follows_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_ack_o == $past(wb_stb_i))
   else $error("wb_ack_o does not follow the strobe of the previous cycle");

   // pins are quiet right after a reset cycle
   gpio_quiet_after_reset: assert property (@(posedge alt_clk)
      $past(alt_rst) |-> gpio_o == '0)
   else $error("gpio_o is not zero after alt_rst");

   // the enable is retimed once inside the accumulator, hence two cycles back
   phase_holds_when_off: assert property (@(posedge alt_clk) disable iff (alt_rst)
      !$past(ena_i, 2) |-> $stable(phase_o))
   else $error("phase_o moved while the accumulator enable was low");

endmodule

bind dsp_ctrl_top dsp_ctrl_assert i_dsp_ctrl_assert (
   .wb_clk_i (wb_clk_i),
   .wb_rst_i (wb_rst_i),
   .wb_stb_i (wb_stb_i),
   .wb_ack_o (wb_ack_o),
   .alt_clk  (alt_clk),
   .alt_rst  (alt_rst),
   .ena_i    (phase_ctrl[dsp_ctrl_pkg::ENA_BIT]),
   .gpio_o   (gpio_o),
   .phase_o  (phase_o)
);

//--- sim/tb_dsp_ctrl_top.sv
`timescale 1ns/1ps

module tb_dsp_ctrl_top;

   import dsp_ctrl_pkg::*;

   logic      wb_clk_i;
   logic      wb_rst_i;
   logic      wb_stb_i;
   logic      wb_we_i;
   wb_addr_t  wb_adr_i;
   byte_sel_t wb_sel_i;
   word_t     wb_dat_i;
   logic      wb_ack_o;
   logic      alt_clk;
   logic      alt_rst;
   logic      run_i;
   word_t     phase_o;
   gpio_t     gpio_o;
   word_t     user_reg4_o;
   word_t     user_reg5_o;
   word_t     user_reg6_o;
   word_t     user_reg7_o;

   // expected contents of the eight settings registers
   word_t     model [NUM_REGS];
   word_t     lcg_state;
   int        errors;
   int        tests_run;
   int        tests_failed;

   dsp_ctrl_top i_dsp_ctrl_top (
      .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .wb_stb_i (wb_stb_i),
      .wb_we_i (wb_we_i), .wb_adr_i (wb_adr_i), .wb_sel_i (wb_sel_i),
      .wb_dat_i (wb_dat_i), .wb_ack_o (wb_ack_o), .alt_clk (alt_clk),
      .alt_rst (alt_rst), .run_i (run_i), .phase_o (phase_o), .gpio_o (gpio_o),
      .user_reg4_o (user_reg4_o), .user_reg5_o (user_reg5_o),
      .user_reg6_o (user_reg6_o), .user_reg7_o (user_reg7_o)
   );

   always #10 alt_clk = ~alt_clk;
   always #30 wb_clk_i = ~wb_clk_i;

   // two LCG steps, keeping only the better upper halves
   function automatic word_t rand_word();
      word_t hi;
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      hi = lcg_state;
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {hi[31:16], lcg_state[31:16]};
   endfunction

   function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                         input byte_sel_t sel);
      word_t res;
      res = old_w;
      for (int b = 0; b < 4; b++)
         if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
      return res;
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      assert (act === exp)
      else
      begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_user(input string name);
      check_word(name, model[4], user_reg4_o);
      check_word(name, model[5], user_reg5_o);
      check_word(name, model[6], user_reg6_o);
      check_word(name, model[7], user_reg7_o);
   endtask

   // one strobe cycle, then the acknowledge and enough time for the crossing
   task automatic bus_access(input string name, input logic we, input wb_addr_t adr,
                             input byte_sel_t sel, input word_t dat);
      int   wait_cnt;
      logic seen;
      @(posedge wb_clk_i);
      #2;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_sel_i = sel;
      wb_dat_i = dat;
      @(posedge wb_clk_i);
      #2;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wait_cnt = 0;
      seen     = wb_ack_o;
      while (!seen && wait_cnt < 10)
      begin
         @(posedge wb_clk_i);
         #2;
         wait_cnt++;
         seen = wb_ack_o;
      end
      assert (seen)
      else
      begin
         $display("%s: no acknowledge arrived within 10 bus cycles", name);
         errors++;
      end
      @(posedge wb_clk_i);
      #2;
      assert (!wb_ack_o)
      else
      begin
         $display("%s: acknowledge stayed high for more than one cycle", name);
         errors++;
      end
      if (we) model[adr[4:2]] = merge_bytes(model[adr[4:2]], dat, sel);
      repeat (8) @(posedge alt_clk);
      #2;
   endtask

   // random upper and lower address bits must alias onto the same register
   task automatic write_random(input string name, input int idx);
      wb_addr_t adr;
      adr = wb_addr_t'(rand_word());
      adr[4:2] = idx[2:0];
      bus_access(name, 1'b1, adr, byte_sel_t'(rand_word()), rand_word());
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors > errs_before)
      begin
         tests_failed++;
         $display("test %s: failed", name);
      end
      else
         $display("test %s: ok", name);
   endtask

   initial
   begin
      int    errs_start;
      word_t r;
      word_t p1;
      word_t snap_phase;
      gpio_t snap_gpio;
      int    n;
      lcg_state = 32'd79416;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      wb_clk_i = 1'b0;
      alt_clk  = 1'b0;
      wb_rst_i = 1'b1;
      alt_rst  = 1'b1;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_adr_i = '0;
      wb_sel_i = '0;
      wb_dat_i = '0;
      run_i    = 1'b0;
      for (int i = 0; i < NUM_REGS; i++) model[i] = '0;
      fork
         begin
            repeat (10) @(posedge alt_clk);
            #2;
            alt_rst = 1'b0;
         end
         begin
            repeat (10) @(posedge wb_clk_i);
            #2;
            wb_rst_i = 1'b0;
         end
      join

      errs_start = errors;
      check_user("reset_state");
      check_word("reset_state phase", '0, phase_o);
      check_word("reset_state gpio", '0, word_t'(gpio_o));
      check_word("reset_state ack", '0, word_t'(wb_ack_o));
      report_test("reset_state", errs_start);

      // writes stay on the spare registers so that reads see quiet outputs
      errs_start = errors;
      for (int i = 0; i < 20; i++)
      begin
         r = rand_word();
         if (r[31])
            write_random("acknowledge write", 4 + int'(r[1:0]));
         else
         begin
            snap_phase = phase_o;
            snap_gpio  = gpio_o;
            bus_access("acknowledge read", 1'b0, r[15:0], r[19:16], rand_word());
            check_word("acknowledge read phase", snap_phase, phase_o);
            check_word("acknowledge read gpio", word_t'(snap_gpio), word_t'(gpio_o));
            check_user("acknowledge read user regs");
         end
      end
      report_test("acknowledge", errs_start);

      errs_start = errors;
      for (int i = 0; i < 40; i++)
      begin
         r = rand_word();
         write_random("byte_lanes", 4 + int'(r[1:0]));
         check_user("byte_lanes");
      end
      report_test("byte_lanes", errs_start);

      errs_start = errors;
      for (int round = 0; round < 4; round++)
      begin
         write_random("gpio idle word", 2);
         write_random("gpio active word", 3);
         for (int i = 0; i < 8; i++)
         begin
            r = rand_word();
            @(posedge alt_clk);
            #2;
            run_i = r[31];
            p1 = run_i ? model[3] : model[2];
            @(posedge alt_clk);
            #2;
            check_word("gpio_select", word_t'(p1[GPIO_W-1:0]), word_t'(gpio_o));
         end
      end
      report_test("gpio_select", errs_start);

      errs_start = errors;
      bus_access("phase increment", 1'b1, 16'h0000, 4'hf, rand_word());
      bus_access("phase enable on", 1'b1, 16'h0004, 4'hf, rand_word() | 32'h1);
      r = rand_word();
      n = 1 + int'(r[4:0]);
      p1 = phase_o;
      repeat (n) @(posedge alt_clk);
      #2;
      check_word("phase_step", p1 + model[0] * word_t'(n), phase_o);
      bus_access("phase enable off", 1'b1, 16'h0004, 4'h1, 32'h0);
      p1 = phase_o;
      for (int i = 0; i < 16; i++)
      begin
         @(posedge alt_clk);
         #2;
         check_word("phase_hold", p1, phase_o);
      end
      report_test("phase_accum", errs_start);

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
      begin
         $display("PASS: all tests");
      end
      else
      begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
